// File: source/sd_cmd_pkg.sv
package sd_cmd_pkg;

  // Command frame layout
  localparam int sd_cmd_content_bits = 40;
  localparam int sd_crc_bits = 7;
  localparam int sd_cmd_frame_bits = 48;

  // x^7 + x^3 + 1, the x^7 term is implicit in the shift
  localparam logic [sd_crc_bits-1:0] sd_crc_poly = 7'h09;

  // Response lengths, start and end bits included
  localparam int sd_rsp_short_bits = 48;
  localparam int sd_rsp_long_bits = 136;

  // Start, transmission and reserved bits ahead of a long response register
  localparam int sd_rsp_long_hdr_bits = 8;

  // Card register content of a long response, without CRC and end bit
  localparam int sd_rsp_reg_bits = sd_rsp_long_bits - sd_rsp_long_hdr_bits - sd_crc_bits - 1;

  // Samples allowed before the start bit is declared missing
  localparam int sd_rsp_timeout_cycles = 64;

  // Counter widths for the two stages
  localparam int sd_tx_cnt_bits = $clog2(sd_cmd_frame_bits + 1);
  localparam int sd_rx_cnt_bits = $clog2(sd_rsp_long_bits + 1);

  typedef enum logic [1:0] {
    sd_rsp_none  = 2'd0,
    sd_rsp_short = 2'd1,
    sd_rsp_long  = 2'd2
  } sd_rsp_kind_t;

  // One host request, index and argument go out as frame content
  typedef struct packed {
    logic [5:0]   index;
    logic [31:0]  arg;
    sd_rsp_kind_t rsp_kind;
  } sd_cmd_req_t;

  // Short response fields, right aligned in the response word
  typedef struct packed {
    logic [sd_rsp_reg_bits-39:0] pad;
    logic [5:0]                  index;
    logic [31:0]                 arg;
  } sd_rsp_short_t;

  // Long response, CID or CSD body
  typedef struct packed {
    logic [sd_rsp_reg_bits-1:0] reg_bits;
  } sd_rsp_long_t;

  // Same word, read by response kind
  typedef union packed {
    sd_rsp_short_t short_view;
    sd_rsp_long_t  long_view;
  } sd_rsp_t;

  typedef struct packed {
    sd_rsp_t rsp;
    logic    crc_err;
    logic    timeout;
  } sd_rsp_result_t;

endpackage

// File: source/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7 (
  input  logic                               i_sd_clk,
  input  logic                               rst,
  input  logic                               i_clear,
  input  logic                               i_en,
  input  logic                               i_bit,
  output logic [sd_cmd_pkg::sd_crc_bits-1:0] o_crc
);
  import sd_cmd_pkg::*;

  logic fb;

  // Incoming bit against the bit falling out of the top
  assign fb = i_bit ^ o_crc[sd_crc_bits-1];

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      // Shift up, fold polynomial taps back in when feedback is set
      o_crc <= {o_crc[sd_crc_bits-2:0], 1'b0} ^ ({sd_crc_bits{fb}} & sd_crc_poly);
    end
  end

endmodule

// File: source/sd_cmd_tx.sv
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic                     i_sd_clk,
  input  logic                     rst,
  input  logic                     i_cmd_stb,
  input  sd_cmd_pkg::sd_cmd_req_t  i_cmd,
  input  logic                     i_done_stb,
  output logic                     o_busy,
  output logic                     o_sd_cmd,
  output logic                     o_sd_cmd_dir,
  output logic                     o_rx_stb,
  output sd_cmd_pkg::sd_rsp_kind_t o_rx_kind
);
  import sd_cmd_pkg::*;

  logic                           accept;
  logic                           released;
  logic                           frame_active;
  logic                           crc_en;
  logic [sd_tx_cnt_bits-1:0]      bit_cnt;
  logic [sd_cmd_content_bits-1:0] shift;
  logic [sd_crc_bits-1:0]         crc;
  logic [sd_crc_bits-1:0]         crc_q;
  sd_rsp_kind_t                   kind_q;

  // Strobes while busy are dropped
  assign accept = i_cmd_stb && !o_busy;

  // Host still owns the pin
  assign frame_active = o_busy && !released;

  // CRC only over start, transmission, index and argument
  assign crc_en = frame_active && (bit_cnt < sd_tx_cnt_bits'(sd_cmd_content_bits));

  // Host takes the pin back on the same edge as done
  assign o_sd_cmd_dir = !released || i_done_stb;

  assign o_rx_kind = kind_q;

  sd_crc7 sd_crc7_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (accept),
    .i_en     (crc_en),
    .i_bit    (shift[sd_cmd_content_bits-1]),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      o_busy   <= 1'b0;
      released <= 1'b0;
      o_rx_stb <= 1'b0;
      o_sd_cmd <= 1'b1;
      bit_cnt  <= '0;
      kind_q   <= sd_rsp_none;
    end else begin
      o_rx_stb <= 1'b0;
      if (accept) begin
        o_busy  <= 1'b1;
        bit_cnt <= '0;
        kind_q  <= i_cmd.rsp_kind;
      end else if (frame_active) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < sd_tx_cnt_bits'(sd_cmd_content_bits)) begin
          // Content bits, MSB first
          o_sd_cmd <= shift[sd_cmd_content_bits-1];
        end else if (bit_cnt == sd_tx_cnt_bits'(sd_cmd_content_bits)) begin
          // Top CRC bit straight from the generator
          o_sd_cmd <= crc[sd_crc_bits-1];
        end else if (bit_cnt < sd_tx_cnt_bits'(sd_cmd_frame_bits)) begin
          // Remaining CRC bits, then the end bit
          o_sd_cmd <= crc_q[sd_crc_bits-1];
        end else begin
          // Frame done, let go of the line and wake the receiver
          o_sd_cmd <= 1'b1;
          released <= 1'b1;
          o_rx_stb <= 1'b1;
        end
      end else if (i_done_stb) begin
        o_busy   <= 1'b0;
        released <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_sd_clk) begin
    // Start 0 and transmission 1 lead the frame
    if (accept) begin
      shift <= {2'b01, i_cmd.index, i_cmd.arg};
    end else if (crc_en) begin
      shift <= {shift[sd_cmd_content_bits-2:0], 1'b0};
    end
    // Ones shifted in behind the CRC form the end bit
    if (frame_active) begin
      if (bit_cnt == sd_tx_cnt_bits'(sd_cmd_content_bits)) begin
        crc_q <= {crc[sd_crc_bits-2:0], 1'b1};
      end else begin
        crc_q <= {crc_q[sd_crc_bits-2:0], 1'b1};
      end
    end
  end

endmodule

// File: source/sd_rsp_rx.sv
`timescale 1ns/1ps

module sd_rsp_rx (
  input  logic                       i_sd_clk,
  input  logic                       rst,
  input  logic                       i_rx_stb,
  input  sd_cmd_pkg::sd_rsp_kind_t   i_rx_kind,
  input  logic                       i_sd_cmd,
  output logic                       o_done_stb,
  output sd_cmd_pkg::sd_rsp_result_t o_result
);
  import sd_cmd_pkg::*;

  logic                       waiting;
  logic                       receiving;
  logic [sd_rx_cnt_bits-1:0]  cnt;
  sd_rsp_kind_t               kind_q;
  sd_rsp_kind_t               kind;
  logic                       is_long;
  logic                       hunt;
  logic                       start;
  logic                       sample;
  logic                       fin_none;
  logic                       fin_tmo;
  logic                       fin_rsp;
  logic                       fin;
  logic                       cov;
  logic                       crc_take;
  logic [sd_rx_cnt_bits-1:0]  idx;
  logic [sd_rx_cnt_bits-1:0]  rsp_len;
  logic [sd_rx_cnt_bits-1:0]  hdr_len;
  logic [sd_rx_cnt_bits-1:0]  crc_lo;
  logic [sd_rsp_reg_bits-1:0] payload;
  logic [sd_crc_bits-1:0]     rx_crc;
  logic [sd_crc_bits-1:0]     crc;
  sd_rsp_t                    rsp;

  // Kind is live on the hand-off cycle, held after that
  assign kind    = i_rx_stb ? i_rx_kind : kind_q;
  assign is_long = (kind == sd_rsp_long);

  // Frame geometry for this kind
  assign rsp_len = is_long ? sd_rx_cnt_bits'(sd_rsp_long_bits)
                           : sd_rx_cnt_bits'(sd_rsp_short_bits);
  assign hdr_len = is_long ? sd_rx_cnt_bits'(sd_rsp_long_hdr_bits) : '0;
  assign crc_lo  = rsp_len - sd_rx_cnt_bits'(sd_crc_bits + 1);

  // Window counts in cnt while waiting
  assign fin_none = i_rx_stb && (i_rx_kind == sd_rsp_none);
  assign fin_tmo  = waiting && (cnt == sd_rx_cnt_bits'(sd_rsp_timeout_cycles));
  assign hunt     = (i_rx_stb && (i_rx_kind != sd_rsp_none)) || (waiting && !fin_tmo);
  assign start    = hunt && !i_sd_cmd;

  // Bit count in cnt while receiving, done one edge after the last bit
  assign fin_rsp = receiving && (cnt == rsp_len);
  assign fin     = fin_none || fin_tmo || fin_rsp;
  assign sample  = start || (receiving && !fin_rsp);
  assign idx     = start ? '0 : cnt;

  // Covered range doubles as the payload range
  assign cov      = sample && (idx >= hdr_len) && (idx < crc_lo);
  assign crc_take = sample && (idx >= crc_lo) && (idx < rsp_len - 1'b1);

  sd_crc7 sd_crc7_i (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (fin),
    .i_en     (cov),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc)
  );

  // Decode the payload into the view for this kind
  always_comb begin
    rsp = '0;
    if (is_long) begin
      rsp.long_view.reg_bits = payload;
    end else begin
      // Start and transmission bits sit above index and argument
      {rsp.short_view.index, rsp.short_view.arg} = payload[sd_cmd_content_bits-3:0];
    end
  end

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      waiting    <= 1'b0;
      receiving  <= 1'b0;
      cnt        <= '0;
      kind_q     <= sd_rsp_none;
      o_done_stb <= 1'b0;
    end else begin
      o_done_stb <= fin;
      if (i_rx_stb) begin
        kind_q <= i_rx_kind;
      end
      if (fin) begin
        waiting   <= 1'b0;
        receiving <= 1'b0;
        cnt       <= '0;
      end else if (start) begin
        // Start bit is the first response bit
        waiting   <= 1'b0;
        receiving <= 1'b1;
        cnt       <= sd_rx_cnt_bits'(1);
      end else if (hunt || receiving) begin
        waiting <= hunt;
        cnt     <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_sd_clk) begin
    if (cov) begin
      payload <= {payload[sd_rsp_reg_bits-2:0], i_sd_cmd};
    end
    if (crc_take) begin
      rx_crc <= {rx_crc[sd_crc_bits-2:0], i_sd_cmd};
    end
    // Timeout and no-response results carry an empty word
    if (fin) begin
      o_result.rsp     <= fin_rsp ? rsp : '0;
      o_result.crc_err <= fin_rsp && (rx_crc != crc);
      o_result.timeout <= fin_tmo;
    end
  end

endmodule

// File: source/sd_cmd_phy.sv
`timescale 1ns/1ps

module sd_cmd_phy (
  input  logic                       i_sd_clk,
  input  logic                       rst,
  input  logic                       i_cmd_stb,
  input  sd_cmd_pkg::sd_cmd_req_t    i_cmd,
  output logic                       o_busy,
  output logic                       o_done_stb,
  output sd_cmd_pkg::sd_rsp_result_t o_result,
  output logic                       o_sd_cmd,
  output logic                       o_sd_cmd_dir,
  input  logic                       i_sd_cmd
);
  import sd_cmd_pkg::*;

  // Hand-off from transmit to receive
  logic         rx_stb;
  sd_rsp_kind_t rx_kind;

  // Done also releases the transmit stage
  logic         done_stb;

  assign o_done_stb = done_stb;

  // Command frame out, pin release, busy flag
  sd_cmd_tx sd_cmd_tx_i (
    .i_sd_clk     (i_sd_clk),
    .rst          (rst),
    .i_cmd_stb    (i_cmd_stb),
    .i_cmd        (i_cmd),
    .i_done_stb   (done_stb),
    .o_busy       (o_busy),
    .o_sd_cmd     (o_sd_cmd),
    .o_sd_cmd_dir (o_sd_cmd_dir),
    .o_rx_stb     (rx_stb),
    .o_rx_kind    (rx_kind)
  );

  // Response capture, CRC check, timeout
  sd_rsp_rx sd_rsp_rx_i (
    .i_sd_clk   (i_sd_clk),
    .rst        (rst),
    .i_rx_stb   (rx_stb),
    .i_rx_kind  (rx_kind),
    .i_sd_cmd   (i_sd_cmd),
    .o_done_stb (done_stb),
    .o_result   (o_result)
  );

endmodule

// File: tb/sd_cmd_phy_checker.sv
`timescale 1ns/1ps

module sd_cmd_phy_checker (
  input logic i_sd_clk,
  input logic rst,
  input logic o_busy,
  input logic o_done_stb,
  input logic o_sd_cmd,
  input logic o_sd_cmd_dir
);

  int fails = 0;

  // Done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge i_sd_clk) disable iff (rst)
    o_done_stb |=> !o_done_stb)
    else begin
      fails++;
      $error("o_done_stb held longer than one cycle");
    end

  // Released line idles high
  line_idle_high: assert property (@(posedge i_sd_clk) disable iff (rst)
    !o_sd_cmd_dir |-> o_sd_cmd)
    else begin
      fails++;
      $error("o_sd_cmd low while o_sd_cmd_dir low");
    end

  // Busy drops right after done
  busy_clears: assert property (@(posedge i_sd_clk) disable iff (rst)
    o_done_stb |=> !o_busy)
    else begin
      fails++;
      $error("o_busy high in the cycle after o_done_stb");
    end

endmodule

bind sd_cmd_phy sd_cmd_phy_checker sd_cmd_phy_checker_i (
  .i_sd_clk     (i_sd_clk),
  .rst          (rst),
  .o_busy       (o_busy),
  .o_done_stb   (o_done_stb),
  .o_sd_cmd     (o_sd_cmd),
  .o_sd_cmd_dir (o_sd_cmd_dir)
);

// File: tb/sd_cmd_phy_tb.sv
`timescale 1ns/1ps

module sd_cmd_phy_tb;
  import sd_cmd_pkg::*;

  // Bound on every wait loop, slack on the start-bit window
  localparam int wait_limit = 400;
  localparam int tmo_margin = 8;

  logic           i_sd_clk;
  logic           rst;
  logic           i_cmd_stb;
  sd_cmd_req_t    i_cmd;
  logic           i_sd_cmd;
  logic           o_busy;
  logic           o_done_stb;
  sd_rsp_result_t o_result;
  logic           o_sd_cmd;
  logic           o_sd_cmd_dir;

  int          errors;
  int          checks;
  int          done_wait;
  logic [31:0] rng_state;

  sd_cmd_phy sd_cmd_phy_i (.*);

  always #4 i_sd_clk = ~i_sd_clk;

  // 32-bit xorshift, one step per call
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // CRC7 x^7+x^3+1 over data[n-1:0], MSB first
  function automatic logic [6:0] crc7_ref(input logic [127:0] data, input int n);
    logic [6:0] c;
    logic       fb;
    int         i;
    c = '0;
    for (i = n - 1; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c  = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic sd_cmd_req_t rand_req(input sd_rsp_kind_t kind);
    sd_cmd_req_t req;
    logic [31:0] r;
    r            = xorshift32();
    req.index    = r[5:0];
    req.arg      = xorshift32();
    req.rsp_kind = kind;
    return req;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Done strobe seen on a falling edge, cycle count kept for the window check
  task automatic wait_done();
    done_wait = 0;
    while (!o_done_stb && done_wait < wait_limit) begin
      @(negedge i_sd_clk);
      done_wait++;
    end
    checks++;
    assert (o_done_stb) else begin
      errors++;
      $display("done strobe missing after %0d cycles at %0t", wait_limit, $time);
    end
  endtask

  // Strobe one request, capture the frame, optional second strobe mid-frame
  task automatic send_cmd(input sd_cmd_req_t req, input logic again, input sd_cmd_req_t other);
    logic [39:0] content;
    logic [47:0] frame;
    int          n;
    content = {2'b01, req.index, req.arg};
    frame   = '0;
    @(negedge i_sd_clk);
    i_cmd     = req;
    i_cmd_stb = 1'b1;
    // Idle bit first, then 48 frame bits; the idle one falls off the top
    for (n = 0; n <= sd_cmd_frame_bits; n++) begin
      @(negedge i_sd_clk);
      i_cmd_stb = again && (n == 10);
      i_cmd     = again ? other : req;
      frame     = {frame[46:0], o_sd_cmd};
      check_val("o_busy", o_busy, 1'b1);
      check_val("o_sd_cmd_dir", o_sd_cmd_dir, 1'b1);
    end
    check_val("o_sd_cmd frame", frame, {content, crc7_ref(128'(content), 40), 1'b1});
  endtask

  // Card model, waits for line release then drives bits[n-1:0] MSB first
  task automatic card_send(input logic [135:0] bits, input int n, input int delay);
    int w;
    int i;
    w = 0;
    while (o_sd_cmd_dir && w < wait_limit) begin
      @(negedge i_sd_clk);
      w++;
    end
    checks++;
    assert (!o_sd_cmd_dir) else begin
      errors++;
      $display("host never released the command line at %0t", $time);
    end
    repeat (delay) @(negedge i_sd_clk);
    for (i = n - 1; i >= 0; i--) begin
      i_sd_cmd = bits[i];
      @(negedge i_sd_clk);
    end
    i_sd_cmd = 1'b1;
  endtask

  // Frame only, no response expected
  task automatic test_frame();
    send_cmd(rand_req(sd_rsp_none), 1'b0, '0);
    wait_done();
    check_val("o_result.crc_err", o_result.crc_err, 1'b0);
    check_val("o_result.timeout", o_result.timeout, 1'b0);
  endtask

  // 48-bit response, flip corrupts one CRC bit
  task automatic test_short(input logic flip);
    sd_cmd_req_t pay;
    logic [39:0] content;
    logic [47:0] rsp;
    pay     = rand_req(sd_rsp_none);
    content = {2'b00, pay.index, pay.arg};
    rsp     = {content, crc7_ref(128'(content), 40), 1'b1};
    rsp[3]  = rsp[3] ^ flip;
    send_cmd(rand_req(sd_rsp_short), 1'b0, '0);
    card_send(136'(rsp), sd_rsp_short_bits, int'(xorshift32() & 32'h7));
    wait_done();
    check_val("o_result.short_view.index", o_result.rsp.short_view.index, pay.index);
    check_val("o_result.short_view.arg", o_result.rsp.short_view.arg, pay.arg);
    check_val("o_result.crc_err", o_result.crc_err, flip);
    check_val("o_result.timeout", o_result.timeout, 1'b0);
  endtask

  // 136-bit response, CRC over the 120 register bits only
  task automatic test_long();
    logic [119:0] body;
    logic [135:0] rsp;
    body = {xorshift32(), xorshift32(), xorshift32(), 24'(xorshift32())};
    rsp  = {8'h3f, body, crc7_ref(128'(body), 120), 1'b1};
    send_cmd(rand_req(sd_rsp_long), 1'b0, '0);
    card_send(rsp, sd_rsp_long_bits, int'(xorshift32() & 32'h7));
    wait_done();
    check_val("o_result.long_view.reg_bits", o_result.rsp.long_view.reg_bits, body);
    check_val("o_result.crc_err", o_result.crc_err, 1'b0);
    check_val("o_result.timeout", o_result.timeout, 1'b0);
  endtask

  // Card stays silent, line held high
  task automatic test_no_start();
    send_cmd(rand_req(sd_rsp_short), 1'b0, '0);
    wait_done();
    check_val("o_result.timeout", o_result.timeout, 1'b1);
    check_val("o_result.rsp", o_result.rsp, '0);
    check_val("start window", (done_wait >= sd_rsp_timeout_cycles) &&
              (done_wait <= sd_rsp_timeout_cycles + tmo_margin), 1'b1);
  endtask

  // Second strobe mid-frame must leave no trace
  task automatic test_busy_strobe();
    int extra;
    int i;
    extra = 0;
    send_cmd(rand_req(sd_rsp_none), 1'b1, rand_req(sd_rsp_short));
    wait_done();
    for (i = 0; i < 2 * sd_rsp_timeout_cycles; i++) begin
      @(negedge i_sd_clk);
      extra += int'(o_done_stb || o_busy);
    end
    check_val("o_done_stb or o_busy after done", extra, 0);
  endtask

  initial begin
    i_sd_clk  = 1'b0;
    rst       = 1'b1;
    i_cmd_stb = 1'b0;
    i_cmd     = '0;
    i_sd_cmd  = 1'b1;
    errors    = 0;
    checks    = 0;
    rng_state = 32'd79;
    repeat (5) @(posedge i_sd_clk);
    @(negedge i_sd_clk);
    rst = 1'b0;
    test_frame();
    test_short(1'b0);
    test_short(1'b1);
    test_long();
    test_no_start();
    test_busy_strobe();
    // Bound assertion failures count too
    errors += sd_cmd_phy_i.sd_cmd_phy_checker_i.fails;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sd_cmd_phy.f
source/sd_cmd_pkg.sv
source/sd_crc7.sv
source/sd_cmd_tx.sv
source/sd_rsp_rx.sv
source/sd_cmd_phy.sv
tb/sd_cmd_phy_checker.sv
tb/sd_cmd_phy_tb.sv

// File: Bender.yml
package:
  name: sd_cmd_phy

sources:
  # SD command line PHY
  - target: rtl
    files:
      - source/sd_cmd_pkg.sv
      - source/sd_crc7.sv
      - source/sd_cmd_tx.sv
      - source/sd_rsp_rx.sv
      - source/sd_cmd_phy.sv
  # Testbench and bound checker
  - target: test
    files:
      - tb/sd_cmd_phy_checker.sv
      - tb/sd_cmd_phy_tb.sv
